/* bench/uart_dbg_assert.sv */
// Bound checks on tx framing and the internal handshakes; bind into uart_dbg_top
`timescale 1ns/1ps

module uart_dbg_assert (
  input logic clk,
  input logic rst_i,
  input logic tx_i,
  input logic tx_req_i,
  input logic tx_ack_i,
  input logic mem_req_i,
  input logic mem_ack_i
);

  import uart_dbg_pkg::*;

  logic       in_frame_q;
  logic [7:0] frame_cnt_q;

  // Bit-cycle position inside the frame, counted from the first low sample
  always_ff @(posedge clk) begin
    if (rst_i) begin
      in_frame_q  <= 1'b0;
      frame_cnt_q <= '0;
    end else if (!in_frame_q) begin
      if (!tx_i) begin
        in_frame_q  <= 1'b1;
        frame_cnt_q <= 8'd1;
      end
    end else begin
      frame_cnt_q <= frame_cnt_q + 1'b1;
      if (32'(frame_cnt_q) == 10 * ClksPerBit - 1) begin
        in_frame_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Serial framing
  ////////////////////////////////////////////////////////////////////////////

  tx_high_in_reset: assert property (@(posedge clk) $past(rst_i) && rst_i |-> tx_i)
    else $error("tx_o is not high during reset");

  start_bit_low: assert property (@(posedge clk) disable iff (rst_i)
    in_frame_q && 32'(frame_cnt_q) < ClksPerBit |-> !tx_i)
    else $error("start bit on tx_o ended early");

  stop_bit_high: assert property (@(posedge clk) disable iff (rst_i)
    in_frame_q && 32'(frame_cnt_q) >= 9 * ClksPerBit |-> tx_i)
    else $error("stop bit on tx_o is low");

  ////////////////////////////////////////////////////////////////////////////
  // Four-phase handshakes
  ////////////////////////////////////////////////////////////////////////////

  mem_ack_with_req: assert property (@(posedge clk) disable iff (rst_i)
    $rose(mem_ack_i) |-> mem_req_i)
    else $error("memory ack rose without a request");

  tx_req_held: assert property (@(posedge clk) disable iff (rst_i)
    tx_req_i && !tx_ack_i |=> tx_req_i)
    else $error("transmit request dropped before its ack");

  tx_ack_release: assert property (@(posedge clk) disable iff (rst_i)
    tx_ack_i && !tx_req_i |=> !tx_ack_i)
    else $error("transmit ack held after the request fell");

endmodule

bind uart_dbg_top uart_dbg_assert i_uart_dbg_assert (
  .clk       (clk),
  .rst_i     (rst_i),
  .tx_i      (tx_o),
  .tx_req_i  (tx_req),
  .tx_ack_i  (tx_ack),
  .mem_req_i (mem_req),
  .mem_ack_i (mem_ack)
);

/* bench/uart_dbg_tb.sv */
// Testbench for the UART debug target; plays the host on rx_i and decodes replies on tx_o
`timescale 1ns/1ps

module uart_dbg_tb;

  import uart_dbg_pkg::*;

  localparam int unsigned Seed = 39624;
  // About 170 frames of 160 cycles in all, with a wide margin
  localparam int unsigned TimeoutCycles = 200_000;
  localparam int unsigned QuietCycles   = 20 * ClksPerBit;

  // Reply bytes as the host expects them on the wire
  localparam byte_t AckReply = 8'h06;
  localparam byte_t EotReply = 8'h04;

  logic  clk;
  logic  rst_i;
  logic  rx_i;
  logic  tx_o;

  byte_t reply_q [$];
  byte_t model_mem [MemDepth];

  uart_dbg_top i_dut (
    .clk   (clk),
    .rst_i (rst_i),
    .rx_i  (rx_i),
    .tx_o  (tx_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("Some tests failed");
    $fatal(1);
  endtask

  initial begin
    int unsigned cycles;
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
    stop_on_failure();
  end

  ////////////////////////////////////////////////////////////////////////////
  // Host serial line
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_byte(input byte_t data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      rx_i = frame[i];
      repeat (ClksPerBit - 1) @(negedge clk);
    end
  endtask

  // Decoder samples each bit near its middle
  initial begin
    byte_t data;
    forever begin
      @(negedge clk);
      if (!rst_i && !tx_o) begin
        repeat (ClksPerBit / 2 - 1) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
          repeat (ClksPerBit) @(negedge clk);
          data[i] = tx_o;
        end
        repeat (ClksPerBit) @(negedge clk);
        if (tx_o !== 1'b1) begin
          $display("framing error: the stop bit on tx_o was not high");
          stop_on_failure();
        end
        reply_q.push_back(data);
      end
    end
  end

  task automatic send_cmd(input byte_t cmd, input byte_t addr, input logic [15:0] len);
    logic [63:0] addr_field;
    logic [63:0] len_field;
    addr_field = 64'(addr);
    len_field  = 64'(len);
    send_byte(cmd);
    for (int k = 0; k < DbgFieldBytes; k++) begin
      send_byte(addr_field[8*k +: 8]);
    end
    for (int k = 0; k < DbgFieldBytes; k++) begin
      send_byte(len_field[8*k +: 8]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reply checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic expect_byte(input string test, input byte_t exp);
    byte_t act;
    while (reply_q.size() == 0) @(negedge clk);
    act = reply_q.pop_front();
    if (act !== exp) begin
      $display("error test=%s expected=%02h actual=%02h", test, exp, act);
      stop_on_failure();
    end
  endtask

  // Line must stay idle and no reply may appear
  task automatic expect_quiet(input string test, input int unsigned cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (tx_o !== 1'b1) begin
        $display("error test=%s expected=1 actual=%b", test, tx_o);
        stop_on_failure();
      end
    end
    if (reply_q.size() != 0) begin
      $display("error test=%s expected=0 bytes actual=%0d bytes", test, reply_q.size());
      stop_on_failure();
    end
  endtask

  task automatic write_block(input string test, input byte_t addr, input int len);
    byte_t data;
    send_cmd(DbgCmdWrite, addr, 16'(len));
    expect_byte(test, AckReply);
    for (int i = 0; i < len; i++) begin
      data = byte_t'($urandom);
      model_mem[mem_addr_t'(addr + i)] = data;
      send_byte(data);
    end
    expect_byte(test, EotReply);
  endtask

  task automatic read_block(input string test, input byte_t addr, input int len);
    send_cmd(DbgCmdRead, addr, 16'(len));
    expect_byte(test, AckReply);
    for (int i = 0; i < len; i++) begin
      expect_byte(test, model_mem[mem_addr_t'(addr + i)]);
    end
    expect_byte(test, EotReply);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Scenarios
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(Seed));
    rst_i = 1'b1;
    rx_i  = 1'b1;
    repeat (10) @(negedge clk);
    rst_i = 1'b0;

    expect_quiet("idle", QuietCycles);

    send_byte(DbgAck);
    expect_byte("challenge", AckReply);
    expect_quiet("challenge", QuietCycles);

    write_block("write", 8'h20, 16);
    read_block("read", 8'h20, 16);

    // Block straddles the top of memory
    write_block("write_wrap", 8'hF8, 16);
    read_block("read_wrap", 8'hF8, 16);

    read_block("read_zero", 8'h20, 0);

    send_byte(8'h13);
    expect_quiet("unknown", QuietCycles);
    send_byte(DbgAck);
    expect_byte("unknown", AckReply);

    $display("All tests passed");
    $finish;
  end

endmodule

/* rtl/dbg_cmd_engine.sv */
// Debug protocol FSM: parses host commands and sequences memory and reply traffic
`timescale 1ns/1ps

module dbg_cmd_engine (
  input  logic                   clk,
  input  logic                   rst_i,
  // Receiver
  input  uart_dbg_pkg::byte_t    rx_data_i,
  input  logic                   rx_valid_i,
  // Transmitter
  output logic                   tx_req_o,
  output uart_dbg_pkg::byte_t    tx_data_o,
  input  logic                   tx_ack_i,
  // Scratch memory
  output logic                   mem_req_o,
  output uart_dbg_pkg::mem_req_t mem_cmd_o,
  input  logic                   mem_ack_i,
  input  uart_dbg_pkg::byte_t    mem_rdata_i
);

  import uart_dbg_pkg::*;

  typedef enum logic [2:0] {
    EngIdle,
    EngAddr,
    EngLen,
    EngAck,
    EngData,
    EngEot
  } eng_state_e;

  eng_state_e                       state_q;
  logic [$clog2(DbgFieldBytes)-1:0] field_cnt_q;
  logic                             field_last;
  mem_addr_t                        addr_q;
  logic [LenWidth-1:0]              len_q;
  logic                             is_read_q;
  logic                             is_chal_q;
  logic                             tx_req_q;
  byte_t                            tx_data_q;
  logic                             mem_req_q;
  mem_req_t                         mem_cmd_q;

  assign field_last = (32'(field_cnt_q) == DbgFieldBytes - 1);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q     <= EngIdle;
      field_cnt_q <= '0;
      addr_q      <= '0;
      len_q       <= '0;
      is_read_q   <= 1'b0;
      is_chal_q   <= 1'b0;
      tx_req_q    <= 1'b0;
      mem_req_q   <= 1'b0;
    end else begin
      case (state_q)

        ////////////////////////////////////////////////////////////////////////////
        // Command and field collection
        ////////////////////////////////////////////////////////////////////////////

        EngIdle: begin
          if (rx_valid_i) begin
            if (rx_data_i == DbgAck) begin
              // Challenge is echoed and the engine returns to idle
              is_chal_q <= 1'b1;
              tx_req_q  <= 1'b1;
              tx_data_q <= DbgAck;
              state_q   <= EngAck;
            end else if (rx_data_i == DbgCmdRead || rx_data_i == DbgCmdWrite) begin
              is_chal_q   <= 1'b0;
              is_read_q   <= (rx_data_i == DbgCmdRead);
              field_cnt_q <= '0;
              state_q     <= EngAddr;
            end
          end
        end
        EngAddr: begin
          if (rx_valid_i) begin
            // Only the lowest address byte reaches the memory
            if (field_cnt_q == '0) begin
              addr_q <= rx_data_i;
            end
            field_cnt_q <= field_cnt_q + 1'b1;
            if (field_last) begin
              field_cnt_q <= '0;
              state_q     <= EngLen;
            end
          end
        end
        EngLen: begin
          if (rx_valid_i) begin
            if (32'(field_cnt_q) < LenWidth / 8) begin
              len_q[8*field_cnt_q +: 8] <= rx_data_i;
            end
            field_cnt_q <= field_cnt_q + 1'b1;
            if (field_last) begin
              field_cnt_q <= '0;
              tx_req_q    <= 1'b1;
              tx_data_q   <= DbgAck;
              state_q     <= EngAck;
            end
          end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Reply bytes and data stream
        ////////////////////////////////////////////////////////////////////////////

        EngAck, EngEot: begin
          if (tx_req_q) begin
            if (tx_ack_i) begin
              tx_req_q <= 1'b0;
            end
          end else if (!tx_ack_i) begin
            if (state_q == EngEot || is_chal_q) begin
              state_q <= EngIdle;
            end else begin
              state_q <= EngData;
            end
          end
        end
        EngData: begin
          if (mem_req_q) begin
            if (mem_ack_i) begin
              mem_req_q <= 1'b0;
              if (is_read_q) begin
                tx_req_q  <= 1'b1;
                tx_data_q <= mem_rdata_i;
              end else begin
                addr_q <= addr_q + 1'b1;
                len_q  <= len_q - 1'b1;
              end
            end
          end else if (tx_req_q) begin
            if (tx_ack_i) begin
              tx_req_q <= 1'b0;
              addr_q   <= addr_q + 1'b1;
              len_q    <= len_q - 1'b1;
            end
          end else if (mem_ack_i || tx_ack_i) begin
            // Wait for the previous handshake to return to zero
          end else if (len_q == '0) begin
            tx_req_q  <= 1'b1;
            tx_data_q <= DbgEot;
            state_q   <= EngEot;
          end else if (is_read_q) begin
            mem_req_q <= 1'b1;
            mem_cmd_q <= '{we: 1'b0, addr: addr_q, wdata: '0};
          end else if (rx_valid_i) begin
            mem_req_q <= 1'b1;
            mem_cmd_q <= '{we: 1'b1, addr: addr_q, wdata: rx_data_i};
          end
        end
        default: state_q <= EngIdle;
      endcase
    end
  end

  assign tx_req_o  = tx_req_q;
  assign tx_data_o = tx_data_q;
  assign mem_req_o = mem_req_q;
  assign mem_cmd_o = mem_cmd_q;

endmodule

/* rtl/dbg_scratch_mem.sv */
// Byte-wide scratch memory behind a four-phase req/ack handshake for the debug engine
`timescale 1ns/1ps

module dbg_scratch_mem (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   req_i,
  input  uart_dbg_pkg::mem_req_t cmd_i,
  output logic                   ack_o,
  output uart_dbg_pkg::byte_t    rdata_o
);

  import uart_dbg_pkg::*;

  byte_t mem_q [MemDepth];
  byte_t rdata_q;
  logic  ack_q;
  logic  new_req;

  // Rising request not yet acknowledged
  assign new_req = req_i && !ack_q;

  // Ack follows req by one cycle in both directions
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_i;
    end
  end

  always_ff @(posedge clk) begin
    if (new_req && cmd_i.we) begin
      mem_q[cmd_i.addr] <= cmd_i.wdata;
    end
  end

  // Read data stays put for as long as ack is high
  always_ff @(posedge clk) begin
    if (new_req && !cmd_i.we) begin
      rdata_q <= mem_q[cmd_i.addr];
    end
  end

  assign ack_o   = ack_q;
  assign rdata_o = rdata_q;

endmodule

/* rtl/uart_dbg_pkg.sv */
// Shared protocol bytes, timing, widths and memory request type; compile before all modules

package uart_dbg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Timing and sizes
  ////////////////////////////////////////////////////////////////////////////

  // Oversampling ratio of the serial line
  localparam int unsigned ClksPerBit    = 16;

  // Address and length fields are 64-bit little-endian on the wire
  localparam int unsigned DbgFieldBytes = 8;

  localparam int unsigned MemAddrWidth  = 8;
  localparam int unsigned MemDepth      = 1 << MemAddrWidth;
  localparam int unsigned LenWidth      = 16;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [7:0] byte_t;
  typedef logic [MemAddrWidth-1:0] mem_addr_t;

  // Request payload, held stable while req is high
  typedef struct packed {
    logic      we;
    mem_addr_t addr;
    byte_t     wdata;
  } mem_req_t;

  ////////////////////////////////////////////////////////////////////////////
  // Protocol bytes
  ////////////////////////////////////////////////////////////////////////////

  localparam byte_t DbgCmdRead  = 8'h11;
  localparam byte_t DbgCmdWrite = 8'h12;
  localparam byte_t DbgAck      = 8'h06;
  localparam byte_t DbgEot      = 8'h04;

endpackage

/* rtl/uart_dbg_top.sv */
// Top level of the UART debug target: receiver, transmitter, command engine and memory
`timescale 1ns/1ps

module uart_dbg_top (
  input  logic clk,
  input  logic rst_i,
  input  logic rx_i,
  output logic tx_o
);

  import uart_dbg_pkg::*;

  byte_t    rx_data;
  logic     rx_valid;
  logic     tx_req;
  byte_t    tx_data;
  logic     tx_ack;
  logic     mem_req;
  mem_req_t mem_cmd;
  logic     mem_ack;
  byte_t    mem_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // Serial line
  ////////////////////////////////////////////////////////////////////////////

  uart_rx i_uart_rx (
    .clk     (clk),
    .rst_i   (rst_i),
    .rx_i    (rx_i),
    .data_o  (rx_data),
    .valid_o (rx_valid)
  );

  uart_tx i_uart_tx (
    .clk    (clk),
    .rst_i  (rst_i),
    .req_i  (tx_req),
    .data_i (tx_data),
    .ack_o  (tx_ack),
    .tx_o   (tx_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Protocol and storage
  ////////////////////////////////////////////////////////////////////////////

  dbg_cmd_engine i_dbg_cmd_engine (
    .clk         (clk),
    .rst_i       (rst_i),
    .rx_data_i   (rx_data),
    .rx_valid_i  (rx_valid),
    .tx_req_o    (tx_req),
    .tx_data_o   (tx_data),
    .tx_ack_i    (tx_ack),
    .mem_req_o   (mem_req),
    .mem_cmd_o   (mem_cmd),
    .mem_ack_i   (mem_ack),
    .mem_rdata_i (mem_rdata)
  );

  dbg_scratch_mem i_dbg_scratch_mem (
    .clk     (clk),
    .rst_i   (rst_i),
    .req_i   (mem_req),
    .cmd_i   (mem_cmd),
    .ack_o   (mem_ack),
    .rdata_o (mem_rdata)
  );

endmodule

/* rtl/uart_rx.sv */
// 8N1 UART receiver with oversampling; emits one strobe per correctly framed byte
`timescale 1ns/1ps

module uart_rx (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                rx_i,
  output uart_dbg_pkg::byte_t data_o,
  output logic                valid_o
);

  import uart_dbg_pkg::*;

  typedef enum logic [1:0] {
    RxIdle,
    RxStart,
    RxData,
    RxStop
  } rx_state_e;

  rx_state_e                     state_q;
  logic [1:0]                    sync_q;
  logic                          rx_s;
  logic [$clog2(ClksPerBit)-1:0] cnt_q;
  logic [2:0]                    bit_idx_q;
  byte_t                         shift_q;
  logic                          valid_q;
  logic                          bit_mid;
  logic                          start_mid;

  // Line idles high, so the synchronizer resets to ones
  always_ff @(posedge clk) begin
    if (rst_i) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rx_i};
    end
  end

  assign rx_s    = sync_q[1];
  assign bit_mid = (32'(cnt_q) == ClksPerBit - 1);
  // Edge detection already costs three cycles, so the half-point check comes early
  assign start_mid = (32'(cnt_q) == ClksPerBit / 2 - 3);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= RxIdle;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      cnt_q   <= cnt_q + 1'b1;
      case (state_q)
        RxIdle: begin
          cnt_q <= '0;
          if (!rx_s) begin
            state_q <= RxStart;
          end
        end
        RxStart: begin
          if (start_mid) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            // Line back high means a glitch, not a start bit
            state_q   <= rx_s ? RxIdle : RxData;
          end
        end
        RxData: begin
          if (bit_mid) begin
            cnt_q     <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= RxStop;
            end
          end
        end
        RxStop: begin
          if (bit_mid) begin
            // Framing error drops the byte silently
            valid_q <= rx_s;
            state_q <= RxIdle;
          end
        end
        default: state_q <= RxIdle;
      endcase
    end
  end

  // LSB arrives first, shift in from the top
  always_ff @(posedge clk) begin
    if (state_q == RxData && bit_mid) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  assign data_o  = shift_q;
  assign valid_o = valid_q;

endmodule

/* rtl/uart_tx.sv */
// 8N1 UART transmitter; sends one byte per four-phase req/ack handshake
`timescale 1ns/1ps

module uart_tx (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                req_i,
  input  uart_dbg_pkg::byte_t data_i,
  output logic                ack_o,
  output logic                tx_o
);

  import uart_dbg_pkg::*;

  typedef enum logic [1:0] {
    TxIdle,
    TxSend,
    TxAck
  } tx_state_e;

  tx_state_e                     state_q;
  logic [$clog2(ClksPerBit)-1:0] cnt_q;
  // 0 is the start bit, 1 to 8 data, 9 the stop bit
  logic [3:0]                    bit_idx_q;
  logic [8:0]                    shift_q;
  logic                          tx_q;
  logic                          ack_q;
  logic                          bit_end;

  assign bit_end = (32'(cnt_q) == ClksPerBit - 1);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= TxIdle;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      tx_q      <= 1'b1;
      ack_q     <= 1'b0;
    end else begin
      case (state_q)
        TxIdle: begin
          if (req_i) begin
            tx_q      <= 1'b0;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            state_q   <= TxSend;
          end
        end
        TxSend: begin
          cnt_q <= cnt_q + 1'b1;
          if (bit_end) begin
            cnt_q <= '0;
            if (bit_idx_q == 4'd9) begin
              // Stop bit done
              ack_q   <= 1'b1;
              state_q <= TxAck;
            end else begin
              tx_q      <= shift_q[0];
              bit_idx_q <= bit_idx_q + 1'b1;
            end
          end
        end
        TxAck: begin
          if (!req_i) begin
            ack_q   <= 1'b0;
            state_q <= TxIdle;
          end
        end
        default: state_q <= TxIdle;
      endcase
    end
  end

  // Data LSB first with the stop bit parked on top, ones fill behind it
  always_ff @(posedge clk) begin
    if (state_q == TxIdle && req_i) begin
      shift_q <= {1'b1, data_i};
    end else if (state_q == TxSend && bit_end) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

  assign tx_o  = tx_q;
  assign ack_o = ack_q;

endmodule

/* run.sh */
#!/bin/sh
# Build the UART debug target with its testbench and run it with Verilator.
# The exit status is nonzero when the build fails or the run fails.
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert \
    --top-module uart_dbg_tb \
    -f uart_dbg.f \
    -o uart_dbg_sim &&
  ./obj_dir/uart_dbg_sim ||
  { echo "simulation did not pass"; exit 1; }

/* uart_dbg.f */
rtl/uart_dbg_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/dbg_cmd_engine.sv
rtl/dbg_scratch_mem.sv
rtl/uart_dbg_top.sv
bench/uart_dbg_assert.sv
bench/uart_dbg_tb.sv
